//--- build.f
hdl/cpu_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/decode_stage.sv
sim/decode_stage_tb.sv

//--- hdl/control_unit.sv
// combinational opcode and funct decode into datapath control levels
`timescale 1ns/10ps
`default_nettype none

module control_unit (
	input  logic [5:0]       opcode,
	input  logic [5:0]       funct,
	output cpu_pkg::aluop_t  alu_op,
	output logic             alu_src,
	output cpu_pkg::ext_t    ext_op,
	output logic             reg_dst,
	output logic             reg_wen,
	output cpu_pkg::wbsel_t  wb_sel,
	output logic             dren,
	output logic             dwen,
	output logic             beq,
	output logic             bne,
	output cpu_pkg::jump_t   jump_sel,
	output logic             jal,
	output logic             halt
);

	always_comb begin
		// defaults form a bubble that writes nothing and touches no memory
		alu_op   = cpu_pkg::alu_add;
		alu_src  = 1'b0;
		ext_op   = cpu_pkg::ext_zero;
		reg_dst  = 1'b0;
		reg_wen  = 1'b0;
		wb_sel   = cpu_pkg::wb_alu;
		dren     = 1'b0;
		dwen     = 1'b0;
		beq      = 1'b0;
		bne      = 1'b0;
		jump_sel = cpu_pkg::jmp_none;
		jal      = 1'b0;
		halt     = 1'b0;

		case (cpu_pkg::opcode_t'(opcode))
			cpu_pkg::op_rtype: begin
				// rd is the destination and funct picks the op
				reg_dst = 1'b1;
				reg_wen = 1'b1;
				case (cpu_pkg::funct_t'(funct))
					cpu_pkg::fn_sll:  alu_op = cpu_pkg::alu_sll;
					cpu_pkg::fn_srl:  alu_op = cpu_pkg::alu_srl;
					cpu_pkg::fn_add,
					cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
					cpu_pkg::fn_sub,
					cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
					cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
					cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
					cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
					cpu_pkg::fn_nor:  alu_op = cpu_pkg::alu_nor;
					cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
					cpu_pkg::fn_sltu: alu_op = cpu_pkg::alu_sltu;
					cpu_pkg::fn_jr: begin
						// register jump to the address on port a
						reg_wen  = 1'b0;
						jump_sel = cpu_pkg::jmp_reg;
					end
					// unknown funct drops the write
					default: reg_wen = 1'b0;
				endcase
			end
			cpu_pkg::op_addi, cpu_pkg::op_addiu: begin
				alu_src = 1'b1;
				ext_op  = cpu_pkg::ext_sign;
				reg_wen = 1'b1;
			end
			cpu_pkg::op_slti, cpu_pkg::op_sltiu: begin
				// sltiu still sign-extends and compares unsigned
				alu_op  = (opcode == cpu_pkg::op_slti) ? cpu_pkg::alu_slt : cpu_pkg::alu_sltu;
				alu_src = 1'b1;
				ext_op  = cpu_pkg::ext_sign;
				reg_wen = 1'b1;
			end
			cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori: begin
				// logical immediates zero-extend
				case (cpu_pkg::opcode_t'(opcode))
					cpu_pkg::op_andi: alu_op = cpu_pkg::alu_and;
					cpu_pkg::op_ori:  alu_op = cpu_pkg::alu_or;
					default:          alu_op = cpu_pkg::alu_xor;
				endcase
				alu_src = 1'b1;
				reg_wen = 1'b1;
			end
			cpu_pkg::op_lui: begin
				// rs is zero in lui so or passes the shifted imm
				alu_op  = cpu_pkg::alu_or;
				alu_src = 1'b1;
				ext_op  = cpu_pkg::ext_upper;
				reg_wen = 1'b1;
			end
			cpu_pkg::op_lw: begin
				alu_src = 1'b1;
				ext_op  = cpu_pkg::ext_sign;
				reg_wen = 1'b1;
				wb_sel  = cpu_pkg::wb_mem;
				dren    = 1'b1;
			end
			cpu_pkg::op_sw: begin
				alu_src = 1'b1;
				ext_op  = cpu_pkg::ext_sign;
				dwen    = 1'b1;
			end
			cpu_pkg::op_beq, cpu_pkg::op_bne: begin
				// compare happens in decode and sub is kept for execute
				alu_op = cpu_pkg::alu_sub;
				ext_op = cpu_pkg::ext_sign;
				beq    = (opcode == cpu_pkg::op_beq);
				bne    = (opcode == cpu_pkg::op_bne);
			end
			cpu_pkg::op_j: jump_sel = cpu_pkg::jmp_addr;
			cpu_pkg::op_jal: begin
				// link into ra with npc
				jump_sel = cpu_pkg::jmp_addr;
				jal      = 1'b1;
				reg_wen  = 1'b1;
				wb_sel   = cpu_pkg::wb_npc;
			end
			cpu_pkg::op_halt: halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
// cpu_pkg: widths, register constants, opcode/funct/alu/extend/jump/writeback enums
`default_nettype none

package cpu_pkg;

	// datapath widths
	localparam int word_w = 32;
	localparam int reg_w = 5;
	localparam int reg_count = 32;

	// link register written by jal
	localparam logic [reg_w-1:0] ra_reg = 5'd31;

	// custom stop opcode
	localparam logic [5:0] halt_op = 6'h3f;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_addiu = 6'h09,
		op_slti  = 6'h0a,
		op_sltiu = 6'h0b,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_xori  = 6'h0e,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b,
		op_halt  = halt_op
	} opcode_t;

	// r-type function codes, instr[5:0]
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_jr   = 6'h08,
		fn_add  = 6'h20,
		fn_addu = 6'h21,
		fn_sub  = 6'h22,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_t;

	// operation handed to execute
	typedef enum logic [3:0] {
		alu_sll  = 4'd0,
		alu_srl  = 4'd1,
		alu_add  = 4'd2,
		alu_sub  = 4'd3,
		alu_and  = 4'd4,
		alu_or   = 4'd5,
		alu_xor  = 4'd6,
		alu_nor  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9
	} aluop_t;

	// immediate extension; upper puts imm in [31:16]
	typedef enum logic [1:0] {ext_zero = 2'd0, ext_sign = 2'd1, ext_upper = 2'd2} ext_t;

	// next-pc source for the hazard unit
	typedef enum logic [1:0] {jmp_none = 2'd0, jmp_addr = 2'd1, jmp_reg = 2'd2} jump_t;

	// writeback source, npc only for jal
	typedef enum logic [1:0] {wb_alu = 2'd0, wb_mem = 2'd1, wb_npc = 2'd2} wbsel_t;

endpackage

`default_nettype wire

//--- hdl/decode_stage.sv
// decode_stage: field split, control/regfile, imm extend, branch/jump resolve, id/ex latch
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  logic                       CLK,
	input  logic                       nRST,
	input  logic [cpu_pkg::word_w-1:0] imemload,
	input  logic [cpu_pkg::word_w-1:0] npc,
	input  logic                       ihit,
	input  logic                       flush,
	input  logic                       freeze,
	input  logic                       wb_reg_wen,
	input  logic [cpu_pkg::reg_w-1:0]  wb_rw,
	input  logic [cpu_pkg::word_w-1:0] wb_port_w,
	output logic [cpu_pkg::reg_w-1:0]  d_rt,
	output logic [cpu_pkg::reg_w-1:0]  d_rw,
	output cpu_pkg::aluop_t            d_alu_op,
	output logic                       d_alu_src,
	output logic                       d_dren,
	output logic                       d_dwen,
	output logic                       d_reg_wen,
	output logic                       d_halt,
	output cpu_pkg::wbsel_t            d_wb_sel,
	output logic [cpu_pkg::word_w-1:0] d_npc,
	output logic [cpu_pkg::word_w-1:0] d_port_a,
	output logic [cpu_pkg::word_w-1:0] d_port_b,
	output logic [cpu_pkg::word_w-1:0] d_imm_ext,
	output logic [cpu_pkg::word_w-1:0] port_a,
	output cpu_pkg::jump_t             jump_sel,
	output logic [cpu_pkg::word_w-1:0] jump_addr,
	output logic                       branch_taken,
	output logic [cpu_pkg::word_w-1:0] branch_addr
);

	// instruction fields
	logic [5:0]                 opcode;
	logic [cpu_pkg::reg_w-1:0]  rs, rt, rd;
	logic [15:0]                imm;
	logic [5:0]                 funct;
	logic [25:0]                target;

	// control levels
	cpu_pkg::aluop_t  alu_op;
	cpu_pkg::ext_t    ext_op;
	cpu_pkg::wbsel_t  wb_sel;
	logic             alu_src, reg_dst, reg_wen, dren, dwen, beq, bne, jal, halt;

	// operands and derived values
	logic [cpu_pkg::word_w-1:0] rdat1, rdat2, imm_ext;
	logic [cpu_pkg::reg_w-1:0]  rw;

	assign opcode = imemload[31:26];
	assign rs     = imemload[25:21];
	assign rt     = imemload[20:16];
	assign rd     = imemload[15:11];
	assign imm    = imemload[15:0];
	assign funct  = imemload[5:0];
	assign target = imemload[25:0];

	control_unit control_unit_inst (
		.opcode(opcode), .funct(funct),
		.alu_op(alu_op), .alu_src(alu_src), .ext_op(ext_op), .reg_dst(reg_dst),
		.reg_wen(reg_wen), .wb_sel(wb_sel), .dren(dren), .dwen(dwen),
		.beq(beq), .bne(bne), .jump_sel(jump_sel), .jal(jal), .halt(halt)
	);

	// write port comes straight from writeback
	register_file register_file_inst (
		.CLK(CLK), .nRST(nRST),
		.wen(wb_reg_wen), .wsel(wb_rw), .wdat(wb_port_w),
		.rsel1(rs), .rsel2(rt),
		.rdat1(rdat1), .rdat2(rdat2)
	);

	// immediate extension
	always_comb begin
		case (ext_op)
			cpu_pkg::ext_sign:  imm_ext = {{16{imm[15]}}, imm};
			cpu_pkg::ext_upper: imm_ext = {imm, 16'h0000};
			default:            imm_ext = {16'h0000, imm};
		endcase
	end

	// destination: ra for jal, rd for r-type, else rt
	assign rw = jal ? cpu_pkg::ra_reg : (reg_dst ? rd : rt);

	// hazard unit outputs, same cycle
	assign port_a       = rdat1;
	assign jump_addr    = {npc[31:28], target, 2'b00};
	assign branch_taken = (beq && (rdat1 == rdat2)) || (bne && (rdat1 != rdat2));
	assign branch_addr  = npc + {imm_ext[29:0], 2'b00};

	// id/ex latch: reset, flush, freeze, ihit
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			d_rt      <= '0;
			d_rw      <= '0;
			d_alu_op  <= cpu_pkg::aluop_t'('0);
			d_alu_src <= 1'b0;
			d_dren    <= 1'b0;
			d_dwen    <= 1'b0;
			d_reg_wen <= 1'b0;
			d_halt    <= 1'b0;
			d_wb_sel  <= cpu_pkg::wbsel_t'('0);
			d_npc     <= '0;
			d_port_a  <= '0;
			d_port_b  <= '0;
			d_imm_ext <= '0;
		end else if (flush) begin
			// bubble into execute
			d_rt      <= '0;
			d_rw      <= '0;
			d_alu_op  <= cpu_pkg::aluop_t'('0);
			d_alu_src <= 1'b0;
			d_dren    <= 1'b0;
			d_dwen    <= 1'b0;
			d_reg_wen <= 1'b0;
			d_halt    <= 1'b0;
			d_wb_sel  <= cpu_pkg::wbsel_t'('0);
			d_npc     <= '0;
			d_port_a  <= '0;
			d_port_b  <= '0;
			d_imm_ext <= '0;
		end else if (!freeze && ihit) begin
			d_rt      <= rt;
			d_rw      <= rw;
			d_alu_op  <= alu_op;
			d_alu_src <= alu_src;
			d_dren    <= dren;
			d_dwen    <= dwen;
			d_reg_wen <= reg_wen;
			d_halt    <= halt;
			d_wb_sel  <= wb_sel;
			d_npc     <= npc;
			d_port_a  <= rdat1;
			d_port_b  <= rdat2;
			d_imm_ext <= imm_ext;
		end
		// freeze or no ihit, hold
	end

	// flushed slot never writes back or halts
	flush_bubble: assert property (
		@(posedge CLK) disable iff (!nRST)
		flush |=> (!d_reg_wen && !d_halt)
	) else $error("decode_stage: flushed bundle still active");

	// frozen bundle does not move
	freeze_hold: assert property (
		@(posedge CLK) disable iff (!nRST)
		(freeze && !flush) |=> $stable({d_rt, d_rw, d_alu_op, d_alu_src, d_dren, d_dwen,
			d_reg_wen, d_halt, d_wb_sel, d_npc, d_port_a, d_port_b, d_imm_ext})
	) else $error("decode_stage: latch changed during freeze");

endmodule

`default_nettype wire

//--- hdl/register_file.sv
// register_file: 32x32 registers, one synchronous write port, two async read ports
`timescale 1ns/10ps
`default_nettype none

module register_file (
	input  logic                       CLK,
	input  logic                       nRST,
	input  logic                       wen,
	input  logic [cpu_pkg::reg_w-1:0]  wsel,
	input  logic [cpu_pkg::word_w-1:0] wdat,
	input  logic [cpu_pkg::reg_w-1:0]  rsel1,
	input  logic [cpu_pkg::reg_w-1:0]  rsel2,
	output logic [cpu_pkg::word_w-1:0] rdat1,
	output logic [cpu_pkg::word_w-1:0] rdat2
);

	// register array
	logic [cpu_pkg::word_w-1:0] regs [cpu_pkg::reg_count];

	// write on rising edge, reg zero never written
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && (wsel != '0)) begin
			regs[wsel] <= wdat;
		end
	end

	// async reads
	// same-cycle write shows only after the edge
	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

	// register zero reads zero on both ports, whatever was written to it
	zero_read_a: assert property (
		@(posedge CLK) disable iff (!nRST)
		(rsel1 == '0) |-> (rdat1 == '0)
	) else $error("register_file: r0 read nonzero on port 1");

	zero_read_b: assert property (
		@(posedge CLK) disable iff (!nRST)
		(rsel2 == '0) |-> (rdat2 == '0)
	) else $error("register_file: r0 read nonzero on port 2");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile the decode stage testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f build.f --top-module decode_stage_tb --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vdecode_stage_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^>>> PASS$' "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1

//--- sim/decode_cases.txt
# W index value | F | Z cycles
# D instr npc port_a port_b imm_ext jsel jaddr btaken baddr rt rw aluop src dren dwen wen halt wbsel
# register file contents, r0 write must not stick
W 01 00000005
W 02 00000005
W 03 fffffff0
W 04 12345678
W 1f 00400000
W 00 deadbeef
# r-type, rs=1 rt=2 rd=5
D 00222820 00400004 00000005 00000005 00002820 0 0088a080 0 0040a084 02 05 2 0 0 0 1 0 0
# freeze with ihit high keeps the add bundle
Z 3
D 00222821 00400004 00000005 00000005 00002821 0 0088a084 0 0040a088 02 05 2 0 0 0 1 0 0
D 00222822 00400004 00000005 00000005 00002822 0 0088a088 0 0040a08c 02 05 3 0 0 0 1 0 0
D 00222823 00400004 00000005 00000005 00002823 0 0088a08c 0 0040a090 02 05 3 0 0 0 1 0 0
D 00222824 00400004 00000005 00000005 00002824 0 0088a090 0 0040a094 02 05 4 0 0 0 1 0 0
D 00222825 00400004 00000005 00000005 00002825 0 0088a094 0 0040a098 02 05 5 0 0 0 1 0 0
D 00222826 00400004 00000005 00000005 00002826 0 0088a098 0 0040a09c 02 05 6 0 0 0 1 0 0
D 00222827 00400004 00000005 00000005 00002827 0 0088a09c 0 0040a0a0 02 05 7 0 0 0 1 0 0
D 0022282a 00400004 00000005 00000005 0000282a 0 0088a0a8 0 0040a0ac 02 05 8 0 0 0 1 0 0
D 0022282b 00400004 00000005 00000005 0000282b 0 0088a0ac 0 0040a0b0 02 05 9 0 0 0 1 0 0
# unknown funct, no write
D 0022283f 00400004 00000005 00000005 0000283f 0 0088a0fc 0 0040a100 02 05 2 0 0 0 0 0 0
# shifts, rs=0 rt=4 rd=6 shamt=4
D 00043100 00400004 00000000 12345678 00003100 0 0010c400 0 0040c404 04 06 0 0 0 0 1 0 0
D 00043102 00400004 00000000 12345678 00003102 0 0010c408 0 0040c40c 04 06 1 0 0 0 1 0 0
# jr r31
D 03e00008 00400004 00400000 00000000 00000008 2 0f800020 0 00400024 00 00 2 0 0 0 0 0 0
# addu r7, r4, r0 with r0 still zero
D 00803821 00400004 12345678 00000000 00003821 0 0200e084 0 0040e088 00 07 2 0 0 0 1 0 0
# unknown opcode gives a bubble
D 70221234 00400004 00000005 00000005 00001234 0 008848d0 0 004048d4 02 02 2 0 0 0 0 0 0
# immediates, rs=1 rt=3, npc top nibble 1
D 2023fff8 10000040 00000005 fffffff0 fffffff8 0 108fffe0 0 10000020 03 03 2 1 0 0 1 0 0
D 24230010 10000040 00000005 fffffff0 00000010 0 108c0040 0 10000080 03 03 2 1 0 0 1 0 0
D 28238000 10000040 00000005 fffffff0 ffff8000 0 108e0000 0 0ffe0040 03 03 8 1 0 0 1 0 0
D 2c237fff 10000040 00000005 fffffff0 00007fff 0 108dfffc 0 1002003c 03 03 9 1 0 0 1 0 0
D 3023ff00 10000040 00000005 fffffff0 0000ff00 0 108ffc00 0 1003fc40 03 03 4 1 0 0 1 0 0
D 34238001 10000040 00000005 fffffff0 00008001 0 108e0004 0 10020044 03 03 5 1 0 0 1 0 0
D 3823abcd 10000040 00000005 fffffff0 0000abcd 0 108eaf34 0 1002af74 03 03 6 1 0 0 1 0 0
# lui with rs=0
D 3c031234 10000040 00000000 fffffff0 12340000 0 100c48d0 0 58d00040 03 03 5 1 0 0 1 0 0
# lw and sw
D 8c230004 10000040 00000005 fffffff0 00000004 0 108c0010 0 10000050 03 03 2 1 1 0 1 0 1
D ac23fffc 10000040 00000005 fffffff0 fffffffc 0 108ffff0 0 10000030 03 03 2 1 0 1 0 0 0
# flush, then branches load normally
F
D 10220003 00400100 00000005 00000005 00000003 0 0088000c 1 0040010c 02 02 3 0 0 0 0 0 0
D 1023fffe 00400100 00000005 fffffff0 fffffffe 0 008ffff8 0 004000f8 03 03 3 0 0 0 0 0 0
D 14220003 00400100 00000005 00000005 00000003 0 0088000c 0 0040010c 02 02 3 0 0 0 0 0 0
D 1423fffe 00400100 00000005 fffffff0 fffffffe 0 008ffff8 1 004000f8 03 03 3 0 0 0 0 0 0
# j and jal keep npc[31:28]
D 08100040 90000200 00000000 00000000 00000040 1 90400100 0 90000300 10 10 2 0 0 0 0 0 0
D 0c000100 90000200 00000000 00000000 00000100 1 90000400 0 90000600 00 1f 2 0 0 0 1 0 2
Z 2
F
# late write then read through rs
W 05 0000abcd
D 00a03820 00400004 0000abcd 00000000 00003820 0 0280e080 0 0040e084 00 07 2 0 0 0 1 0 0
# halt
D fc000000 00400200 00000000 00000000 00000000 0 00000000 0 00400200 00 00 2 0 0 0 0 1 0

//--- sim/decode_stage_tb.sv
// decode_stage_tb: clock, reset, case file reader, stimulus tasks, value checks, report
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;

	// run limits
	localparam int max_cycles = 5000;
	localparam int max_lines  = 1000;
	localparam int max_freeze = 16;
	// halt word on the fetch latch while the stage must not load
	localparam logic [31:0] idle_word = 32'hffff_ffff;

	logic                       CLK, nRST;
	logic [cpu_pkg::word_w-1:0] imemload, npc;
	logic                       ihit, flush, freeze;
	logic                       wb_reg_wen;
	logic [cpu_pkg::reg_w-1:0]  wb_rw;
	logic [cpu_pkg::word_w-1:0] wb_port_w;

	// latched bundle
	logic [cpu_pkg::reg_w-1:0]  d_rt, d_rw;
	cpu_pkg::aluop_t            d_alu_op;
	logic                       d_alu_src, d_dren, d_dwen, d_reg_wen, d_halt;
	cpu_pkg::wbsel_t            d_wb_sel;
	logic [cpu_pkg::word_w-1:0] d_npc, d_port_a, d_port_b, d_imm_ext;

	// same-cycle hazard outputs
	logic [cpu_pkg::word_w-1:0] port_a, jump_addr, branch_addr;
	cpu_pkg::jump_t             jump_sel;
	logic                       branch_taken;

	int          check_count;
	int          check_errors;
	int          file_errors;
	int          seed;
	// expected bundle, same order as check_bundle
	logic [31:0] held [13];
	// fields of the current case line
	logic [31:0] f [18];

	decode_stage decode_stage_inst (
		.CLK(CLK), .nRST(nRST),
		.imemload(imemload), .npc(npc),
		.ihit(ihit), .flush(flush), .freeze(freeze),
		.wb_reg_wen(wb_reg_wen), .wb_rw(wb_rw), .wb_port_w(wb_port_w),
		.d_rt(d_rt), .d_rw(d_rw), .d_alu_op(d_alu_op), .d_alu_src(d_alu_src),
		.d_dren(d_dren), .d_dwen(d_dwen), .d_reg_wen(d_reg_wen), .d_halt(d_halt),
		.d_wb_sel(d_wb_sel), .d_npc(d_npc), .d_port_a(d_port_a), .d_port_b(d_port_b),
		.d_imm_ext(d_imm_ext),
		.port_a(port_a), .jump_sel(jump_sel), .jump_addr(jump_addr),
		.branch_taken(branch_taken), .branch_addr(branch_addr)
	);

	// 100 ns clock
	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// watchdog over the whole run
	initial begin
		for (int cyc = 0; cyc < max_cycles; cyc++) begin
			@(posedge CLK);
		end
		$display("timeout: run still going after %0d clock cycles", max_cycles);
		$display(">>> FAIL");
		$finish;
	end

	task automatic check(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			check_errors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// latched outputs against held[]
	task automatic check_bundle(input string when);
		check({when, ": d_rt"}, 32'(d_rt), held[0]);
		check({when, ": d_rw"}, 32'(d_rw), held[1]);
		check($sformatf("%s: d_alu_op %s", when, d_alu_op.name()), 32'(d_alu_op), held[2]);
		check({when, ": d_alu_src"}, 32'(d_alu_src), held[3]);
		check({when, ": d_dren"}, 32'(d_dren), held[4]);
		check({when, ": d_dwen"}, 32'(d_dwen), held[5]);
		check({when, ": d_reg_wen"}, 32'(d_reg_wen), held[6]);
		check({when, ": d_halt"}, 32'(d_halt), held[7]);
		check($sformatf("%s: d_wb_sel %s", when, d_wb_sel.name()), 32'(d_wb_sel), held[8]);
		check({when, ": d_npc"}, d_npc, held[9]);
		check({when, ": d_port_a"}, d_port_a, held[10]);
		check({when, ": d_port_b"}, d_port_b, held[11]);
		check({when, ": d_imm_ext"}, d_imm_ext, held[12]);
	endtask

	// bubble after reset or flush
	task automatic clear_bundle();
		for (int i = 0; i < 13; i++) begin
			held[i] = '0;
		end
	endtask

	task automatic report_line(input int line_no, input string msg);
		file_errors++;
		$display("case file line %0d is unusable: %s", line_no, msg);
	endtask

	// one writeback cycle
	task automatic apply_write(input logic [31:0] idx, input logic [31:0] value);
		@(posedge CLK);
		wb_reg_wen <= 1'b1;
		wb_rw      <= idx[cpu_pkg::reg_w-1:0];
		wb_port_w  <= value;
		@(posedge CLK);
		wb_reg_wen <= 1'b0;
	endtask

	// present f[0] with ihit for one edge, then check both sides
	task automatic apply_decode(input int line_no);
		string tag;
		tag = $sformatf("line %0d", line_no);
		@(posedge CLK);
		imemload <= f[0];
		npc      <= f[1];
		ihit     <= 1'b1;
		flush    <= 1'b0;
		freeze   <= 1'b0;
		// combinational side settles before the falling edge
		@(negedge CLK);
		check({tag, ": port_a"}, port_a, f[2]);
		check($sformatf("%s: jump_sel %s", tag, jump_sel.name()), 32'(jump_sel), f[5]);
		check({tag, ": jump_addr"}, jump_addr, f[6]);
		check({tag, ": branch_taken"}, 32'(branch_taken), f[7]);
		check({tag, ": branch_addr"}, branch_addr, f[8]);
		@(posedge CLK);
		ihit     <= 1'b0;
		imemload <= idle_word;
		@(negedge CLK);
		held[0]  = f[9];
		held[1]  = f[10];
		held[2]  = f[11];
		held[3]  = f[12];
		held[4]  = f[13];
		held[5]  = f[14];
		held[6]  = f[15];
		held[7]  = f[16];
		held[8]  = f[17];
		held[9]  = f[1];
		held[10] = f[2];
		held[11] = f[3];
		held[12] = f[4];
		check_bundle(tag);
	endtask

	// ihit low, latch must hold
	task automatic idle_gap(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge CLK);
			@(negedge CLK);
			check_bundle("idle");
		end
	endtask

	// freeze with ihit high, latch must hold
	task automatic apply_freeze(input int cycles);
		@(posedge CLK);
		freeze <= 1'b1;
		ihit   <= 1'b1;
		for (int i = 0; i < cycles; i++) begin
			@(posedge CLK);
			if (i == cycles - 1) begin
				freeze <= 1'b0;
				ihit   <= 1'b0;
			end
			@(negedge CLK);
			check_bundle("freeze");
		end
	endtask

	// flush wins over freeze and ihit
	task automatic apply_flush();
		@(posedge CLK);
		flush  <= 1'b1;
		ihit   <= 1'b1;
		freeze <= 1'b1;
		@(posedge CLK);
		flush  <= 1'b0;
		ihit   <= 1'b0;
		freeze <= 1'b0;
		@(negedge CLK);
		clear_bundle();
		check_bundle("flush");
	endtask

	initial begin
		int    fd;
		int    status;
		int    line_no;
		int    fields;
		int    gap;
		int    decodes;
		byte   cmd;
		string line;
		string rest;

		check_count  = 0;
		check_errors = 0;
		file_errors  = 0;
		decodes      = 0;
		seed         = 32'h89a9;
		nRST       <= 1'b0;
		imemload   <= idle_word;
		npc        <= '0;
		ihit       <= 1'b0;
		flush      <= 1'b0;
		freeze     <= 1'b0;
		wb_reg_wen <= 1'b0;
		wb_rw      <= '0;
		wb_port_w  <= '0;
		repeat (2) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		clear_bundle();
		check_bundle("after reset");

		fd = $fopen("sim/decode_cases.txt", "r");
		if (fd == 0) begin
			file_errors++;
			$display("could not open sim/decode_cases.txt");
		end else begin
			line_no = 0;
			while (line_no < max_lines) begin
				status = $fgets(line, fd);
				if (status == 0) break;
				line_no++;
				cmd = line.getc(0);
				// comments and blank lines
				if (cmd == "#" || cmd == "\n" || cmd == "\r") continue;
				rest = line.substr(1, line.len() - 1);
				case (cmd)
					"W": begin
						fields = $sscanf(rest, "%h %h", f[0], f[1]);
						if (fields != 2) report_line(line_no, "W needs an index and a value");
						else apply_write(f[0], f[1]);
					end
					"D": begin
						fields = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
							f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
							f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
						if (fields != 18) begin
							report_line(line_no, $sformatf("D has %0d of 18 fields", fields));
						end else begin
							decodes++;
							apply_decode(line_no);
							gap = $unsigned($random(seed)) % 4;
							idle_gap(gap);
						end
					end
					"F": apply_flush();
					"Z": begin
						fields = $sscanf(rest, "%h", f[0]);
						if (fields != 1 || f[0] == 0 || f[0] > max_freeze)
							report_line(line_no, "Z needs a cycle count from 1 to 16");
						else apply_freeze(int'(f[0]));
					end
					default: report_line(line_no, "unknown command letter");
				endcase
			end
			if (line_no >= max_lines) begin
				file_errors++;
				$display("case file has more than %0d lines, the rest was not read", max_lines);
			end
			if (decodes == 0) begin
				file_errors++;
				$display("case file holds no instruction lines");
			end
			$fclose(fd);
		end

		$display("checks run: %0d, value mismatches: %0d, case file problems: %0d",
			check_count, check_errors, file_errors);
		if (check_errors == 0 && file_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
